// ==== hdl/fsqrt_pkg.sv ====
`default_nettype none

package fsqrt_pkg;

    // IEEE single precision field widths.
    localparam int EXP_BITS  = 8;
    localparam int FRAC_BITS = 23;

    // Significand root, leading one included.
    localparam int ROOT_BITS = 24;

    // Radicand significand with two integer bits.
    localparam int RAD_BITS = 25;

    // Carry-save remainder, wide enough for the sign of the last used step.
    localparam int REM_BITS = ROOT_BITS + 3;

    // Half of the exponent bias, rounded down.
    localparam int HALF_BIAS = 63;

    typedef struct packed {
        logic                 sign;
        logic [EXP_BITS-1:0]  exp;
        logic [FRAC_BITS-1:0] frac;
    } float_t;

    // One operand in flight through the recurrence pipeline.
    typedef struct packed {
        logic                   valid;
        logic                   sign;
        logic [EXP_BITS-1:0]    exp;
        logic [2*ROOT_BITS-1:0] rad;       // Unconsumed bits, MSB first.
        logic [ROOT_BITS-1:0]   root;
        logic [REM_BITS-1:0]    rem_sum;
        logic [REM_BITS-1:0]    rem_carry;
    } pipe_t;

endpackage

`default_nettype wire

// ==== hdl/fsqrt_unpack.sv ====
`timescale 1ns/1ps
`default_nettype none

module fsqrt_unpack (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              valid_input,
    input  fsqrt_pkg::float_t radicand,
    output fsqrt_pkg::pipe_t  pipe_out
);

    localparam int EXP_BITS  = fsqrt_pkg::EXP_BITS;
    localparam int ROOT_BITS = fsqrt_pkg::ROOT_BITS;
    localparam int RAD_BITS  = fsqrt_pkg::RAD_BITS;
    localparam int REM_BITS  = fsqrt_pkg::REM_BITS;

    fsqrt_pkg::float_t   in_q;
    logic                valid_q;
    logic [RAD_BITS-1:0] rad_sig;
    logic [EXP_BITS-1:0] exp_half;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= valid_input;
        end
    end

    always_ff @(posedge clk) begin
        if (valid_input) begin
            in_q <= radicand;
        end
    end

    // Odd exponent keeps m, even exponent doubles it.
    assign rad_sig = in_q.exp[0] ? {2'b01, in_q.frac} : {1'b1, in_q.frac, 1'b0};

    assign exp_half = {1'b0, in_q.exp[EXP_BITS-1:1]} + EXP_BITS'(fsqrt_pkg::HALF_BIAS)
                    + EXP_BITS'(in_q.exp[0]);

    // The top pair is taken here. Its root bit is always one,
    // so the first subtraction of one is folded into the remainder.
    always_comb begin
        pipe_out.valid     = valid_q;
        pipe_out.sign      = in_q.sign;
        pipe_out.exp       = exp_half;
        pipe_out.rad       = {rad_sig[RAD_BITS-3:0], {(2*ROOT_BITS-RAD_BITS+2){1'b0}}};
        pipe_out.root      = '0;
        pipe_out.rem_sum   = REM_BITS'(rad_sig[RAD_BITS-1 -: 2]) - REM_BITS'(1);
        pipe_out.rem_carry = '0;
    end

endmodule

`default_nettype wire

// ==== hdl/sqrt_step.sv ====
`timescale 1ns/1ps
`default_nettype none

module sqrt_step (
    input  logic [fsqrt_pkg::REM_BITS-1:0]  rem_sum_in,
    input  logic [fsqrt_pkg::REM_BITS-1:0]  rem_carry_in,
    input  logic [fsqrt_pkg::ROOT_BITS-1:0] root_in,
    input  logic [1:0]                      rad_bits,
    output logic [fsqrt_pkg::REM_BITS-1:0]  rem_sum_out,
    output logic [fsqrt_pkg::REM_BITS-1:0]  rem_carry_out,
    output logic [fsqrt_pkg::ROOT_BITS-1:0] root_out
);

    localparam int W         = fsqrt_pkg::REM_BITS;
    localparam int ROOT_BITS = fsqrt_pkg::ROOT_BITS;

    logic [W-1:0] rem_full;
    logic         q_bit;
    logic [W-1:0] shifted_sum;
    logic [W-1:0] shifted_carry;
    logic [W-1:0] corr;
    logic [W-1:0] maj;

    // One full add per step to resolve the sign.
    assign rem_full = rem_sum_in + rem_carry_in;
    assign q_bit    = ~rem_full[W-1];  // Non-negative gives a one.

    assign root_out = {root_in[ROOT_BITS-2:0], q_bit};

    // Subtract 4Q+1 when the remainder is non-negative, add 4Q+3 otherwise.
    // Both come out as the root, conditionally inverted, over 2'b11.
    assign corr = {{root_in, q_bit} ^ {(W-2){q_bit}}, 2'b11};

    // Remainder times four, next radicand pair in the free low bits.
    assign shifted_sum   = {rem_sum_in[W-3:0], rad_bits};
    assign shifted_carry = {rem_carry_in[W-3:0], 2'b00};

    // 3:2 compressor.
    assign rem_sum_out = shifted_sum ^ shifted_carry ^ corr;
    assign maj = (shifted_sum & shifted_carry)
               | (shifted_sum & corr)
               | (shifted_carry & corr);
    assign rem_carry_out = {maj[W-2:0], 1'b0};  // Stored pre-shifted.

endmodule

`default_nettype wire

// ==== hdl/sqrt_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module sqrt_stage #(
    parameter int STAGE_BITS = 2
) (
    input  logic             clk,
    input  logic             rst_n,
    input  fsqrt_pkg::pipe_t pipe_in,
    output fsqrt_pkg::pipe_t pipe_out
);

    localparam int REM_BITS  = fsqrt_pkg::REM_BITS;
    localparam int ROOT_BITS = fsqrt_pkg::ROOT_BITS;
    localparam int RAD_W     = 2 * ROOT_BITS;

    logic [REM_BITS-1:0]  sum_chain   [STAGE_BITS+1];
    logic [REM_BITS-1:0]  carry_chain [STAGE_BITS+1];
    logic [ROOT_BITS-1:0] root_chain  [STAGE_BITS+1];
    logic [RAD_W-1:0]     rad_next;

    assign sum_chain[0]   = pipe_in.rem_sum;
    assign carry_chain[0] = pipe_in.rem_carry;
    assign root_chain[0]  = pipe_in.root;

    for (genvar j = 0; j < STAGE_BITS; j++) begin : g_step
        // Step j takes the j-th pair from the top of rad.
        sqrt_step step_inst (
            .rem_sum_in    (sum_chain[j]),
            .rem_carry_in  (carry_chain[j]),
            .root_in       (root_chain[j]),
            .rad_bits      (pipe_in.rad[RAD_W-1-2*j -: 2]),
            .rem_sum_out   (sum_chain[j+1]),
            .rem_carry_out (carry_chain[j+1]),
            .root_out      (root_chain[j+1])
        );
    end

    assign rad_next = pipe_in.rad << (2 * STAGE_BITS);  // Drop consumed pairs.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pipe_out <= '0;
        end else begin
            pipe_out.valid <= pipe_in.valid;
            // Payload follows valid operands only, so idle slots keep the last result.
            if (pipe_in.valid) begin
                pipe_out.sign      <= pipe_in.sign;
                pipe_out.exp       <= pipe_in.exp;
                pipe_out.rad       <= rad_next;
                pipe_out.root      <= root_chain[STAGE_BITS];
                pipe_out.rem_sum   <= sum_chain[STAGE_BITS];
                pipe_out.rem_carry <= carry_chain[STAGE_BITS];
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/fsqrt.sv ====
`timescale 1ns/1ps
`default_nettype none

module fsqrt #(
    parameter int STAGE_BITS = 2
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              valid_input,
    input  fsqrt_pkg::float_t radicand,
    output logic              valid_output,
    output fsqrt_pkg::float_t y
);

    localparam int NUM_STAGES = fsqrt_pkg::ROOT_BITS / STAGE_BITS;

    // pipe[0] comes from the front end, pipe[NUM_STAGES] is the result.
    fsqrt_pkg::pipe_t pipe [NUM_STAGES+1];

    fsqrt_unpack unpack_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .valid_input (valid_input),
        .radicand    (radicand),
        .pipe_out    (pipe[0])
    );

    for (genvar i = 0; i < NUM_STAGES; i++) begin : g_stage
        sqrt_stage #(
            .STAGE_BITS (STAGE_BITS)
        ) stage_inst (
            .clk      (clk),
            .rst_n    (rst_n),
            .pipe_in  (pipe[i]),
            .pipe_out (pipe[i+1])
        );
    end

    assign valid_output = pipe[NUM_STAGES].valid;

    // Leading one of the root is implicit in the output word.
    assign y.sign = pipe[NUM_STAGES].sign;
    assign y.exp  = pipe[NUM_STAGES].exp;
    assign y.frac = pipe[NUM_STAGES].root[fsqrt_pkg::FRAC_BITS-1:0];

endmodule

`default_nettype wire

// ==== bench/fsqrt_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module fsqrt_tb;

    localparam int  STAGE_BITS  = 2;
    localparam int  NUM_STAGES  = fsqrt_pkg::ROOT_BITS / STAGE_BITS;
    localparam int  NUM_TESTS   = 23;
    localparam int  MAX_CYCLES  = NUM_TESTS * 4 + NUM_STAGES + 20;
    localparam int  RESET_CYCLES = 8;
    localparam time CLK_PERIOD  = 4ns;
    localparam time DRIVE_DELAY = 1ns;

    logic              clk = 1'b0;
    logic              rst_n;
    logic              valid_input;
    fsqrt_pkg::float_t radicand;
    logic              valid_output;
    fsqrt_pkg::float_t y;

    // Raw file contents, radicand and expected word interleaved.
    logic [31:0] test_words [2*NUM_TESTS];
    logic [31:0] rad_words  [NUM_TESTS];
    logic [31:0] exp_words  [NUM_TESTS];

    logic [31:0] expect_q [$];
    int          issue_q  [$];   // Edge on which each operand was sampled.

    int cycle;
    int results;
    bit first_seen;

    fsqrt #(
        .STAGE_BITS (STAGE_BITS)
    ) fsqrt_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .valid_input  (valid_input),
        .radicand     (radicand),
        .valid_output (valid_output),
        .y            (y)
    );

    // Prints the reason, then ends the run as failed.
    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_value(
        input logic [31:0] actual,
        input logic [31:0] expected,
        input string       what
    );
        if (actual !== expected) begin
            stop_run($sformatf("mismatch at %0t: %s, got %h, expected %h",
                               $time, what, actual, expected));
        end
    endtask

    initial begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Counts edges after reset release.
    always @(posedge clk) begin
        if (rst_n) begin
            cycle <= cycle + 1;
        end
    end

    always @(negedge clk) begin
        if (cycle >= MAX_CYCLES) begin
            stop_run($sformatf("Timeout: run did not finish within %0d cycles, %0d results seen",
                               MAX_CYCLES, results));
        end
    end

    // Result monitor, sampled away from the active edge.
    always @(negedge clk) begin
        int issued_at;
        logic [31:0] want;
        if (valid_output) begin
            if (!rst_n) begin
                stop_run("valid_output was high while reset was asserted");
            end else if (expect_q.size() == 0) begin
                stop_run("valid_output was raised with no operand outstanding");
            end else begin
                issued_at = issue_q.pop_front();
                want      = expect_q.pop_front();
                check_value(cycle - issued_at, NUM_STAGES,
                            $sformatf("latency of result %0d", results));
                check_value(y, want, $sformatf("result %0d", results));
                first_seen = 1'b1;
                results    = results + 1;
            end
        end else if (!first_seen) begin
            check_value(y, 32'h0, "y before the first result");
        end
    end

    initial begin
        int gap;
        rst_n       = 1'b0;
        valid_input = 1'b0;
        radicand    = '0;
        cycle       = 0;
        results     = 0;
        first_seen  = 1'b0;
        void'($urandom(32'h22ac));

        for (int k = 0; k < 2 * NUM_TESTS; k++) begin
            test_words[k] = 'x;
        end
        $readmemh("bench/fsqrt_tests.txt", test_words);
        for (int i = 0; i < NUM_TESTS; i++) begin
            rad_words[i] = test_words[2*i];
            exp_words[i] = test_words[2*i+1];
            if ($isunknown(rad_words[i]) || $isunknown(exp_words[i])) begin
                stop_run($sformatf("Test file has no valid data for test %0d", i));
            end
        end

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;

        for (int i = 0; i < NUM_TESTS; i++) begin
            // Tests 6 to 11 and 18 onwards go back to back.
            if ((i / 6) % 2 == 1) begin
                gap = 0;
            end else begin
                gap = $urandom % 4;
            end
            repeat (gap) begin
                @(posedge clk);
                #DRIVE_DELAY;
                valid_input = 1'b0;
                radicand    = $urandom;  // Junk that must not load.
            end
            @(posedge clk);
            #DRIVE_DELAY;
            valid_input = 1'b1;
            radicand    = rad_words[i];
            expect_q.push_back(exp_words[i]);
            issue_q.push_back(cycle + 1);
        end
        @(posedge clk);
        #DRIVE_DELAY;
        valid_input = 1'b0;
        radicand    = '0;

        while (expect_q.size() != 0) begin
            @(negedge clk);
        end
        @(negedge clk);
        #DRIVE_DELAY;  // Let the monitor finish its last sample.

        $display("Checked %0d results.", results);
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/fsqrt_tests.txt ====
// radicand word, expected root word (truncated significand)
// 1.0 4.0 0.25 9.0 16 2.25 100 0.0625 2 8 0.5 1.5 3 6 12 2.5 5 10 -4 -2 -1.5 -9 -5
3F800000 3F800000
40800000 40000000
3E800000 3F000000
41100000 40400000
41800000 40800000
40100000 3FC00000
42C80000 41200000
3D800000 3E800000
40000000 3FB504F3
41000000 403504F3
3F000000 3F3504F3
3FC00000 3F9CC470
40400000 3FDDB3D7
40C00000 401CC470
41400000 405DB3D7
40200000 3FCA62C1
40A00000 400F1BBC
41200000 404A62C1
C0800000 C0000000
C0000000 BFB504F3
BFC00000 BF9CC470
C1100000 C0400000
C0A00000 C00F1BBC

// ==== sim.f ====
hdl/fsqrt_pkg.sv
hdl/fsqrt_unpack.sv
hdl/sqrt_step.sv
hdl/sqrt_stage.sv
hdl/fsqrt.sv
bench/fsqrt_tb.sv

// ==== Bender.yml ====
package:
  name: fsqrt

sources:
  # Package first, then leaf modules, then the top level.
  - files:
      - hdl/fsqrt_pkg.sv
      - hdl/fsqrt_unpack.sv
      - hdl/sqrt_step.sv
      - hdl/sqrt_stage.sv
      - hdl/fsqrt.sv
  - target: simulation
    files:
      - bench/fsqrt_tb.sv
